/* mem_front_end.f */
+incdir+source
source/mem_front_end_pkg.sv
source/icache_tag_table.sv
source/icache.sv
source/dmem_port.sv
source/mem_front_end.sv
bench/mem_model.sv
bench/mem_front_end_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f mem_front_end.f \
		--top-module mem_front_end_tb -o mem_front_end_sim
	./obj_dir/mem_front_end_sim > sim.log
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/mem_front_end_tb.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module mem_front_end_tb;
  import mem_front_end_pkg::*;

  localparam int FETCH_SEQ  = 300;
  localparam int FETCH_HITS = 100;
  localparam int DATA_SEQ   = 400;
  localparam int MIXED_OPS  = 600;   // per side
  localparam int NUM_OPS    = FETCH_SEQ + FETCH_HITS + DATA_SEQ + 2 * MIXED_OPS;
  localparam int MAX_CYCLES = NUM_OPS * 40;   // worst case per operation
  localparam int BLOCKS     = 1 << (`MEM_ADDR_W - `BLOCK_OFF_W);

  logic                   clock;
  logic                   rst_n;
  mem_req_t               mem_req;
  mem_reply_t             mem_reply;
  logic [`MEM_ADDR_W-1:0] fetch_addr;
  logic [63:0]            fetch_data;
  logic                   fetch_valid;
  logic                   dreq_valid;
  logic                   dreq_store;
  logic [`MEM_ADDR_W-1:0] dreq_addr;
  logic [63:0]            dreq_data;
  logic                   dport_busy;
  logic                   dresp_done;
  logic [63:0]            dresp_data;

  logic [63:0]              ref_mem [BLOCKS];
  logic [`MEM_ADDR_W-1:0]   fetch_set [16];   // lower half only
  logic [`MEM_ADDR_W-1:0]   data_set [16];    // upper half only
  logic [`ICACHE_LINES-1:0] line_known;       // cache contents as seen from outside
  logic [`MEM_ADDR_W-`BLOCK_OFF_W-1:0] line_blk [`ICACHE_LINES];

  string cur_test;
  int    checks = 0;
  int    errors = 0;
  int    test_checks;
  int    test_errors;
  int    done_count = 0;
  int    refusals = 0;
  int    cycles = 0;

  mem_front_end u_dut (
    .clock       (clock),
    .rst_n       (rst_n),
    .mem_req     (mem_req),
    .mem_reply   (mem_reply),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .dreq_valid  (dreq_valid),
    .dreq_store  (dreq_store),
    .dreq_addr   (dreq_addr),
    .dreq_data   (dreq_data),
    .dport_busy  (dport_busy),
    .dresp_done  (dresp_done),
    .dresp_data  (dresp_data)
  );

  mem_model u_mem (
    .clock     (clock),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_reply (mem_reply)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic compare_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      errors = errors + 1;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", cur_test,
             checks - test_checks, errors - test_errors);
  endtask

  // waits until the block shows up, same cycle if the line already holds it
  task automatic fetch_block(input logic [`MEM_ADDR_W-1:0] addr);
    logic [`ICACHE_IDX_W-1:0]            idx;
    logic [`MEM_ADDR_W-`BLOCK_OFF_W-1:0] blk;
    logic                                expect_hit;
    idx        = addr[`BLOCK_OFF_W +: `ICACHE_IDX_W];
    blk        = addr[`MEM_ADDR_W-1:`BLOCK_OFF_W];
    expect_hit = line_known[idx] && (line_blk[idx] == blk);
    @(posedge clock);
    fetch_addr <= addr;
    @(negedge clock);
    if (expect_hit) compare_val(cur_test, 64'd1, 64'(fetch_valid));
    while (!fetch_valid) @(negedge clock);
    line_known[idx] = 1'b1;
    line_blk[idx]   = blk;
  endtask

  // one blocking load or store through the data port
  task automatic data_access(input logic store, input logic [`MEM_ADDR_W-1:0] addr,
                             input logic [63:0] data);
    logic [`MEM_ADDR_W-`BLOCK_OFF_W-1:0] blk;
    logic                                accepted;
    blk      = addr[`MEM_ADDR_W-1:`BLOCK_OFF_W];
    accepted = 1'b0;
    @(negedge clock);
    while (dport_busy) @(negedge clock);
    @(posedge clock);
    dreq_valid <= 1'b1;
    dreq_store <= store;
    dreq_addr  <= addr;
    dreq_data  <= data;
    @(posedge clock);
    dreq_valid <= 1'b0;
    @(negedge clock);
    while (!dresp_done) begin
      if (dport_busy && !accepted) begin   // data side must own the bus
        compare_val(cur_test, store ? BUS_STORE : BUS_LOAD, mem_req.cmd);
        compare_val(cur_test, {blk, 3'b000}, mem_req.addr);
        if (store) compare_val(cur_test, data, mem_req.data);
        accepted = (mem_reply.response != '0);
      end
      @(negedge clock);
    end
    compare_val(cur_test, 64'd1, 64'(accepted));
    if (store) begin
      ref_mem[blk] = data;
    end else begin
      compare_val(cur_test, ref_mem[blk], dresp_data);
    end
    @(negedge clock);
    compare_val(cur_test, 64'd0, 64'(dresp_done));   // single-cycle pulse
  endtask

  task automatic random_access();
    logic                   store;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [63:0]            data;
    store = 1'($urandom);
    if (store || ($urandom % 4) != 0) begin
      addr = data_set[4'($urandom)];
    end else begin
      addr = fetch_set[4'($urandom)];   // some loads read code blocks
    end
    data = {$urandom, $urandom};
    data_access(store, addr, data);
  endtask

  // fetch data and completion monitor
  always @(negedge clock) begin
    if (rst_n && fetch_valid) begin
      compare_val(cur_test, ref_mem[fetch_addr[`MEM_ADDR_W-1:`BLOCK_OFF_W]], fetch_data);
    end
    if (rst_n && dresp_done) done_count = done_count + 1;
    if (rst_n && mem_req.cmd != BUS_NONE && mem_reply.response == '0) begin
      refusals = refusals + 1;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with requests still outstanding", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    logic [`ICACHE_IDX_W-1:0] k;
    void'($urandom(32'h9f413cc9));
    rst_n      = 1'b0;
    fetch_addr = '0;
    dreq_valid = 1'b0;
    dreq_store = 1'b0;
    dreq_addr  = '0;
    dreq_data  = '0;
    line_known = '0;
    cur_test   = "reset_state";
    for (int a = 0; a < BLOCKS; a++) begin
      ref_mem[a] = 64'(a) * 64'h9e37_79b9_7f4a_7c15 + ~64'(a);
    end
    // eight indices for sixteen blocks, so some lines get evicted
    for (int i = 0; i < 16; i++) begin
      fetch_set[i] = {1'b0, 7'($urandom), 2'b00, 3'($urandom), 3'($urandom)};
      data_set[i]  = {1'b1, 12'($urandom), 3'($urandom)};
    end

    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    start_test("reset_state");
    compare_val(cur_test, BUS_NONE, mem_req.cmd);
    compare_val(cur_test, 64'd0, 64'(fetch_valid));
    compare_val(cur_test, 64'd0, 64'(dport_busy));
    compare_val(cur_test, 64'd0, 64'(dresp_done));
    finish_test();

    start_test("fetch_data");
    repeat (FETCH_SEQ) fetch_block(fetch_set[4'($urandom)]);
    finish_test();

    start_test("cache_hits");
    repeat (FETCH_HITS) begin
      k = 5'($urandom % 8);
      if (line_known[k]) fetch_block({line_blk[k], 3'($urandom)});
      else fetch_block(fetch_set[4'($urandom)]);
    end
    finish_test();

    start_test("loads_stores");
    repeat (DATA_SEQ) random_access();
    repeat (2) @(posedge clock);
    compare_val(cur_test, DATA_SEQ, done_count);
    finish_test();

    start_test("bus_priority");
    fork
      repeat (MIXED_OPS) fetch_block(fetch_set[4'($urandom)]);
      repeat (MIXED_OPS) random_access();
    join
    repeat (2) @(posedge clock);
    compare_val(cur_test, DATA_SEQ + MIXED_OPS, done_count);
    finish_test();

    start_test("backpressure");
    @(negedge clock);
    compare_val(cur_test, 64'd1, 64'(refusals > 0));
    compare_val(cur_test, BUS_NONE, mem_req.cmd);   // no fill or data request left
    compare_val(cur_test, 64'd0, 64'(dport_busy));
    finish_test();

    $display("total: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module mem_model (
  input  logic                          clock,
  input  logic                          rst_n,
  input  mem_front_end_pkg::mem_req_t   mem_req,
  output mem_front_end_pkg::mem_reply_t mem_reply
);
  import mem_front_end_pkg::*;

  localparam int BLOCKS = 1 << (`MEM_ADDR_W - `BLOCK_OFF_W);

  logic [63:0]           mem [BLOCKS];
  logic [`MEM_TAGS-1:0]  busy;            // load reply still owed on this tag
  logic [2:0]            delay [`MEM_TAGS];
  logic [63:0]           held [`MEM_TAGS];
  logic [`MEM_TAG_W-1:0] next_tag;        // rotation start
  logic [`MEM_TAG_W-1:0] grant_tag;
  logic [`MEM_TAG_W-1:0] due_tag;
  logic                  accept_ok;       // drawn once per cycle
  logic [`MEM_TAG_W-1:0] reply_tag;
  logic [63:0]           reply_data;
  logic [`MEM_ADDR_W-`BLOCK_OFF_W-1:0] blk;

  // fill rule: block address times a constant plus its inverse
  initial begin
    for (int a = 0; a < BLOCKS; a++) begin
      mem[a] = 64'(a) * 64'h9e37_79b9_7f4a_7c15 + ~64'(a);
    end
  end

  assign blk = mem_req.addr[`MEM_ADDR_W-1:`BLOCK_OFF_W];

  // first free tag from the rotation pointer on
  always_comb begin
    int cand;
    grant_tag = '0;
    for (int k = 0; k < `MEM_TAGS - 1; k++) begin
      cand = ((int'(next_tag) - 1 + k) % (`MEM_TAGS - 1)) + 1;
      if (grant_tag == '0 && !busy[cand] && cand[`MEM_TAG_W-1:0] != reply_tag) begin
        grant_tag = cand[`MEM_TAG_W-1:0];
      end
    end
  end

  // lowest tag whose wait is over
  always_comb begin
    due_tag = '0;
    for (int t = `MEM_TAGS - 1; t > 0; t--) begin
      if (busy[t] && delay[t] == '0) due_tag = t[`MEM_TAG_W-1:0];
    end
  end

  always_comb begin
    mem_reply.response = '0;
    if (rst_n && accept_ok && mem_req.cmd != BUS_NONE) begin
      mem_reply.response = grant_tag;
    end
    mem_reply.data = reply_data;
    mem_reply.tag  = reply_tag;
  end

  always @(posedge clock) begin
    if (!rst_n) begin
      busy       <= '0;
      next_tag   <= 4'd1;
      accept_ok  <= 1'b0;
      reply_tag  <= '0;
      reply_data <= '0;
    end else begin
      accept_ok  <= ($urandom % 3) != 0;   // about a third refused
      reply_tag  <= due_tag;                 // one reply per cycle at most
      reply_data <= held[due_tag];
      for (int t = 1; t < `MEM_TAGS; t++) begin
        if (busy[t] && delay[t] != '0) delay[t] <= delay[t] - 1'b1;
      end
      if (due_tag != '0) busy[due_tag] <= 1'b0;
      if (mem_reply.response != '0) begin
        next_tag <= (grant_tag == `MEM_TAGS - 1) ? 4'd1 : grant_tag + 1'b1;
        if (mem_req.cmd == BUS_STORE) begin
          mem[blk] <= mem_req.data;          // stores get no reply
        end else begin
          busy[grant_tag]  <= 1'b1;
          delay[grant_tag] <= 3'($urandom % 7 + 1);
          held[grant_tag]  <= mem[blk];
        end
      end
    end
  end

endmodule

/* source/mem_front_end.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module mem_front_end (
  input  logic                          clock,
  input  logic                          rst_n,
  output mem_front_end_pkg::mem_req_t   mem_req,
  input  mem_front_end_pkg::mem_reply_t mem_reply,
  input  logic [`MEM_ADDR_W-1:0]        fetch_addr,
  output logic [63:0]                   fetch_data,
  output logic                          fetch_valid,
  input  logic                          dreq_valid,
  input  logic                          dreq_store,
  input  logic [`MEM_ADDR_W-1:0]        dreq_addr,
  input  logic [63:0]                   dreq_data,
  output logic                          dport_busy,
  output logic                          dresp_done,
  output logic [63:0]                   dresp_data
);
  import mem_front_end_pkg::*;

  mem_req_t              imem_req;
  mem_req_t              dmem_req;
  logic [`MEM_TAG_W-1:0] imem_response;
  logic [`MEM_TAG_W-1:0] dmem_response;
  logic                  bus_select;    // high when the icache owns the bus

  // data side wins whenever it drives a command
  assign bus_select    = (dmem_req.cmd == BUS_NONE);
  assign mem_req       = bus_select ? imem_req : dmem_req;
  assign imem_response = bus_select ? mem_reply.response : '0;
  assign dmem_response = bus_select ? '0 : mem_reply.response;

  icache u_icache (
    .clock          (clock),
    .rst_n          (rst_n),
    .fetch_addr     (fetch_addr),
    .fetch_data     (fetch_data),
    .fetch_valid    (fetch_valid),
    .imem_req       (imem_req),
    .imem_response  (imem_response),
    .mem_reply_data (mem_reply.data),
    .mem_reply_tag  (mem_reply.tag)
  );

  dmem_port u_dmem_port (
    .clock          (clock),
    .rst_n          (rst_n),
    .dreq_valid     (dreq_valid),
    .dreq_store     (dreq_store),
    .dreq_addr      (dreq_addr),
    .dreq_data      (dreq_data),
    .dmem_req       (dmem_req),
    .dmem_response  (dmem_response),
    .mem_reply_data (mem_reply.data),   // both sides see every reply
    .mem_reply_tag  (mem_reply.tag),
    .dport_busy     (dport_busy),
    .dresp_done     (dresp_done),
    .dresp_data     (dresp_data)
  );

endmodule

/* source/dmem_port.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module dmem_port (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        dreq_valid,
  input  logic                        dreq_store,
  input  logic [`MEM_ADDR_W-1:0]      dreq_addr,
  input  logic [63:0]                 dreq_data,
  output mem_front_end_pkg::mem_req_t dmem_req,
  input  logic [`MEM_TAG_W-1:0]       dmem_response,
  input  logic [63:0]                 mem_reply_data,
  input  logic [`MEM_TAG_W-1:0]       mem_reply_tag,
  output logic                        dport_busy,
  output logic                        dresp_done,    // one-cycle end pulse
  output logic [63:0]                 dresp_data
);
  import mem_front_end_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_REQ  = 2'd1,   // command on the bus
    ST_WAIT = 2'd2    // load accepted, waiting for its tag
  } dport_state_e;

  dport_state_e           state;
  logic                   req_store;
  logic [`MEM_ADDR_W-1:0] req_addr;
  logic [63:0]            req_data;
  logic [`MEM_TAG_W-1:0]  acc_tag;
  logic                   accepted;
  logic                   reply_hit;

  assign accepted  = (state == ST_REQ) && (dmem_response != '0);
  assign reply_hit = (state == ST_WAIT) && (mem_reply_tag == acc_tag);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      dresp_done <= 1'b0;
    end else begin
      dresp_done <= 1'b0;
      case (state)
        ST_IDLE: if (dreq_valid) state <= ST_REQ;
        ST_REQ: begin
          if (accepted) begin
            state      <= req_store ? ST_IDLE : ST_WAIT;
            dresp_done <= req_store;   // stores finish at acceptance
          end
        end
        ST_WAIT: begin
          if (reply_hit) begin
            state      <= ST_IDLE;
            dresp_done <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == ST_IDLE) && dreq_valid) begin
      req_store <= dreq_store;
      req_addr  <= {dreq_addr[`MEM_ADDR_W-1:`BLOCK_OFF_W], {`BLOCK_OFF_W{1'b0}}};
      req_data  <= dreq_data;
    end
    if (accepted) acc_tag <= dmem_response;
    if (reply_hit) dresp_data <= mem_reply_data;
  end

  always_comb begin
    dmem_req.cmd  = BUS_NONE;
    dmem_req.addr = req_addr;
    dmem_req.data = req_data;
    if (state == ST_REQ) begin
      dmem_req.cmd = req_store ? BUS_STORE : BUS_LOAD;
    end
  end

  assign dport_busy = (state != ST_IDLE);

endmodule

/* source/icache.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module icache (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [`MEM_ADDR_W-1:0]      fetch_addr,
  output logic [63:0]                 fetch_data,
  output logic                        fetch_valid,
  output mem_front_end_pkg::mem_req_t imem_req,
  input  logic [`MEM_TAG_W-1:0]       imem_response,   // 0 while refused or bus is taken
  input  logic [63:0]                 mem_reply_data,
  input  logic [`MEM_TAG_W-1:0]       mem_reply_tag
);
  import mem_front_end_pkg::*;

  icache_line_t             lines [`ICACHE_LINES];
  logic [`ICACHE_TAG_W-1:0] fill_tags [`ICACHE_LINES]; // cache tag of the fill in flight

  // fetch address split
  logic [`ICACHE_IDX_W-1:0] rd_idx;
  logic [`ICACHE_TAG_W-1:0] rd_tag;
  logic                     hit;

  // miss request held until memory takes it
  logic                     req_valid;
  logic [`MEM_ADDR_W-1:0]   req_addr;
  logic [`ICACHE_IDX_W-1:0] req_idx;
  logic [`ICACHE_TAG_W-1:0] req_tag;
  logic                     req_accept;

  // tag table interface
  logic                     lookup_pending;
  logic                     fill_en;
  logic [`ICACHE_IDX_W-1:0] fill_idx;

  assign rd_idx = fetch_addr[`BLOCK_OFF_W +: `ICACHE_IDX_W];
  assign rd_tag = fetch_addr[`MEM_ADDR_W-1 -: `ICACHE_TAG_W];

  assign req_idx = req_addr[`BLOCK_OFF_W +: `ICACHE_IDX_W];
  assign req_tag = req_addr[`MEM_ADDR_W-1 -: `ICACHE_TAG_W];

  // hit path is purely combinational
  always_comb begin
    hit         = lines[rd_idx].valid && (lines[rd_idx].tag == rd_tag);
    fetch_valid = hit;
    fetch_data  = lines[rd_idx].data;
  end

  assign req_accept = req_valid && (imem_response != '0);

  // new miss only when the port is free and no fill is due for this line
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else if (req_valid) begin
      if (req_accept) begin
        req_valid <= 1'b0;
      end
    end else if (!hit && !lookup_pending) begin
      req_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!req_valid) begin
      req_addr <= {fetch_addr[`MEM_ADDR_W-1:`BLOCK_OFF_W], {`BLOCK_OFF_W{1'b0}}};
    end
  end

  always_comb begin
    imem_req      = '0;
    imem_req.cmd  = req_valid ? BUS_LOAD : BUS_NONE;
    imem_req.addr = req_addr;
  end

  // remember which cache tag the accepted fill belongs to
  always_ff @(posedge clock) begin
    if (req_accept) begin
      fill_tags[req_idx] <= req_tag;
    end
  end

  // line storage, only valid bits are cleared
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < `ICACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (fill_en) begin
      lines[fill_idx].valid <= 1'b1;
      lines[fill_idx].tag   <= fill_tags[fill_idx];
      lines[fill_idx].data  <= mem_reply_data;
    end
  end

  icache_tag_table u_tag_table (
    .clock          (clock),
    .rst_n          (rst_n),
    .record_en      (req_accept),
    .record_tag     (imem_response),
    .record_idx     (req_idx),
    .reply_tag      (mem_reply_tag),
    .lookup_idx     (rd_idx),
    .lookup_pending (lookup_pending),
    .fill_en        (fill_en),
    .fill_idx       (fill_idx)
  );

endmodule

/* source/icache_tag_table.sv */
`timescale 1ns/10ps
`include "mem_front_end_consts.svh"

module icache_tag_table (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     record_en,   // fill request accepted this cycle
  input  logic [`MEM_TAG_W-1:0]    record_tag,
  input  logic [`ICACHE_IDX_W-1:0] record_idx,
  input  logic [`MEM_TAG_W-1:0]    reply_tag,
  input  logic [`ICACHE_IDX_W-1:0] lookup_idx,
  output logic                     lookup_pending,
  output logic                     fill_en,
  output logic [`ICACHE_IDX_W-1:0] fill_idx
);

  // one entry per memory tag
  logic [`MEM_TAGS-1:0]     pending;
  logic [`ICACHE_IDX_W-1:0] line_idx [`MEM_TAGS];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      if (fill_en) begin
        pending[reply_tag] <= 1'b0;   // entry freed as the fill lands
      end
      if (record_en) begin
        pending[record_tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (record_en) begin
      line_idx[record_tag] <= record_idx;
    end
  end

  // a matching reply on a pending tag is a fill
  assign fill_en  = (reply_tag != '0) && pending[reply_tag];
  assign fill_idx = line_idx[reply_tag];

  // is some fill already headed for this line
  always_comb begin
    lookup_pending = 1'b0;
    for (int t = 1; t < `MEM_TAGS; t++) begin
      if (pending[t] && (line_idx[t] == lookup_idx)) begin
        lookup_pending = 1'b1;
      end
    end
  end

endmodule

/* source/mem_front_end_pkg.sv */
`include "mem_front_end_consts.svh"

package mem_front_end_pkg;

  // bus command encoding, same as the core's memory bus
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // request toward memory, held until the response tag is nonzero
  typedef struct packed {
    bus_cmd_e               cmd;
    logic [`MEM_ADDR_W-1:0] addr;   // block aligned
    logic [63:0]            data;   // store data only
  } mem_req_t;

  // everything memory drives back in one cycle
  typedef struct packed {
    logic [`MEM_TAG_W-1:0] response; // 0 = request refused
    logic [63:0]           data;     // load data for tag below
    logic [`MEM_TAG_W-1:0] tag;      // 0 = nothing arriving
  } mem_reply_t;

  // one direct-mapped instruction cache line
  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [63:0]              data;
  } icache_line_t;

endpackage

/* source/mem_front_end_consts.svh */
`ifndef MEM_FRONT_END_CONSTS_SVH
`define MEM_FRONT_END_CONSTS_SVH

// address bits carried on the memory bus
`define MEM_ADDR_W    16

// byte offset inside one 64-bit block
`define BLOCK_OFF_W   3

// instruction cache geometry
`define ICACHE_IDX_W  5
`define ICACHE_LINES  32
`define ICACHE_TAG_W  8     // address bits above index and offset

// memory transaction tags, tag 0 is reserved
`define MEM_TAG_W     4
`define MEM_TAGS      16

`endif
